// File: Bender.yml
package:
  name: exec_core

export_include_dirs:
  - include

sources:
  - files:
      - rtl/definitions.sv
      - rtl/main_decoder.sv
      - rtl/alu_op.sv
      - rtl/alu.sv
      - rtl/reg_file.sv
      - rtl/exec_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/exec_core_properties.sv
      - tests/exec_core_tb.sv

// File: include/core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// ------------------------------------------------------------------------
// Core sizing
// ------------------------------------------------------------------------

`define XLEN       32  // Data width.
`define REG_COUNT  32  // Architectural registers.
`define REG_ADDR_W 5   // Bits of a register index.

`endif

// File: rtl/alu.sv
`timescale 1ns/1ps

module alu (
    input  definitions::word_t          opA,
    input  definitions::word_t          opB,
    input  definitions::alu_operation_t opSel,
    output definitions::word_t          result
);

    logic [4:0]         shamt;
    definitions::flag_t ltSigned;
    definitions::flag_t ltUnsigned;

    // ------------------------------------------------------------------------
    // Shared terms
    // ------------------------------------------------------------------------

    assign shamt      = opB[4:0];  // RV32 shifts use five bits.
    assign ltSigned   = ($signed(opA) < $signed(opB)) ? definitions::HIGH : definitions::LOW;
    assign ltUnsigned = (opA < opB) ? definitions::HIGH : definitions::LOW;

    // ------------------------------------------------------------------------
    // Result select
    // ------------------------------------------------------------------------

    always_comb begin : aluCompute
        case (opSel)
            definitions::ADD: begin
                result = opA + opB;
            end
            definitions::SUB: begin
                result = opA - opB;
            end
            definitions::SLL: begin
                result = opA << shamt;
            end
            definitions::SLT: begin
                result = definitions::word_t'(ltSigned);  // Zero or one.
            end
            definitions::SLTU: begin
                result = definitions::word_t'(ltUnsigned);
            end
            definitions::XOR: begin
                result = opA ^ opB;
            end
            definitions::SRL: begin
                result = opA >> shamt;
            end
            definitions::SRA: begin
                result = definitions::word_t'($signed(opA) >>> shamt);  // Sign fill.
            end
            definitions::OR: begin
                result = opA | opB;
            end
            definitions::AND: begin
                result = opA & opB;
            end
            definitions::FWD: begin
                result = opA;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule : alu

// File: rtl/alu_op.sv
`timescale 1ns/1ps

module alu_op (
    input  definitions::aluOp_t         aluOp,
    input  logic [6:0]                  funct7,
    input  logic [2:0]                  funct3,
    output definitions::alu_operation_t opSel,
    output definitions::flag_t          error
);

    // funct3 encodings in instruction bits 14:12.
    typedef enum logic [2:0] {
        f3AddSub = 3'd0,
        f3Sll    = 3'd1,
        f3Slt    = 3'd2,
        f3Sltu   = 3'd3,
        f3Xor    = 3'd4,
        f3SrlSra = 3'd5,
        f3Or     = 3'd6,
        f3And    = 3'd7
    } funct3Op_t;

    // funct7 encodings in instruction bits 31:25.
    typedef enum logic [6:0] {
        f7Base = 7'd0,
        f7Alt  = 7'd32
    } funct7Op_t;

    definitions::alu_operation_t nextOpSel;
    definitions::flag_t          sendError;

    always_comb begin : aluOpSel
        nextOpSel = definitions::ADD;
        sendError = definitions::LOW;
        case (aluOp)
            definitions::TYPE_I: begin
                case (funct3)
                    f3AddSub : nextOpSel = definitions::ADD;
                    f3Slt    : nextOpSel = definitions::SLT;
                    f3Xor    : nextOpSel = definitions::XOR;
                    f3Or     : nextOpSel = definitions::OR;
                    f3And    : nextOpSel = definitions::AND;
                    default  : sendError = definitions::HIGH;  // Shift-imm and SLTIU.
                endcase
            end
            definitions::TYPE_R: begin
                case (funct7)
                    f7Base: begin
                        case (funct3)
                            f3AddSub : nextOpSel = definitions::ADD;
                            f3Sll    : nextOpSel = definitions::SLL;
                            f3Slt    : nextOpSel = definitions::SLT;
                            f3Sltu   : nextOpSel = definitions::SLTU;
                            f3Xor    : nextOpSel = definitions::XOR;
                            f3SrlSra : nextOpSel = definitions::SRL;
                            f3Or     : nextOpSel = definitions::OR;
                            f3And    : nextOpSel = definitions::AND;
                        endcase
                    end
                    f7Alt: begin
                        case (funct3)
                            f3AddSub : nextOpSel = definitions::SUB;
                            f3SrlSra : nextOpSel = definitions::SRA;
                            default  : sendError = definitions::HIGH;
                        endcase
                    end
                    default: begin
                        sendError = definitions::HIGH;  // Unsupported extension.
                    end
                endcase
            end
            definitions::DEF_ADD : nextOpSel = definitions::ADD;
            definitions::PASS_S1 : nextOpSel = definitions::FWD;
        endcase
    end

    assign opSel = nextOpSel;
    assign error = sendError;

endmodule : alu_op

// File: rtl/definitions.sv
`include "core_cfg.svh"

package definitions;

    // --------------------------------------------------------------------
    // Plain vector types
    // --------------------------------------------------------------------

    typedef logic [`XLEN-1:0]       word_t;     // One data word.
    typedef logic [`REG_ADDR_W-1:0] regAddr_t;  // Register index.
    typedef logic                   flag_t;     // Single control bit.

    localparam flag_t HIGH = 1'b1;
    localparam flag_t LOW  = 1'b0;

    // --------------------------------------------------------------------
    // Decoder and ALU encodings
    // --------------------------------------------------------------------

    // Instruction class handed from the main decoder to alu_op.
    typedef enum logic [1:0] {
        TYPE_I  = 2'd0,  // Register-immediate arithmetic.
        TYPE_R  = 2'd1,  // Register-register arithmetic.
        DEF_ADD = 2'd2,  // Address add for loads and stores.
        PASS_S1 = 2'd3   // Forward source one.
    } aluOp_t;

    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLL  = 4'd2,
        SLT  = 4'd3,
        SLTU = 4'd4,
        XOR  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        OR   = 4'd8,
        AND  = 4'd9,
        FWD  = 4'd10     // Result is operand A.
    } alu_operation_t;

    // Major opcodes handled by this slice, bits 6:0 of the instruction.
    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111
    } opcode_t;

endpackage : definitions

// File: rtl/exec_core.sv
`timescale 1ns/1ps

module exec_core (
    input  logic                  clk,
    input  logic                  rst,
    input  definitions::flag_t    instrValid,
    input  definitions::word_t    instr,
    output definitions::flag_t    wbValid,
    output definitions::regAddr_t wbAddr,
    output definitions::word_t    wbData,
    output definitions::flag_t    illegal
);

    definitions::regAddr_t       rs1;
    definitions::regAddr_t       rs2;
    definitions::regAddr_t       rd;
    logic [2:0]                  funct3;
    logic [6:0]                  funct7;
    definitions::word_t          imm;
    definitions::aluOp_t         aluOp;
    definitions::flag_t          srcAImm;
    definitions::flag_t          srcBImm;
    definitions::flag_t          opIllegal;
    definitions::alu_operation_t opSel;
    definitions::flag_t          error;
    definitions::word_t          rs1Data;
    definitions::word_t          rs2Data;
    definitions::word_t          opA;
    definitions::word_t          opB;
    definitions::word_t          result;
    definitions::flag_t          reject;
    definitions::flag_t          wrEn;

    // ------------------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------------------

    main_decoder uMainDecoder (
        .instr    (instr),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .funct3   (funct3),
        .funct7   (funct7),
        .imm      (imm),
        .aluOp    (aluOp),
        .srcAImm  (srcAImm),
        .srcBImm  (srcBImm),
        .opIllegal(opIllegal)
    );

    alu_op uAluOp (
        .aluOp (aluOp),
        .funct7(funct7),
        .funct3(funct3),
        .opSel (opSel),
        .error (error)
    );

    // ------------------------------------------------------------------------
    // Operands and execute
    // ------------------------------------------------------------------------

    reg_file uRegFile (
        .clk    (clk),
        .rst    (rst),
        .rs1Addr(rs1),
        .rs2Addr(rs2),
        .wrAddr (rd),
        .wrEn   (wrEn),
        .wrData (result),
        .rs1Data(rs1Data),
        .rs2Data(rs2Data)
    );

    assign opA = srcAImm ? imm : rs1Data;  // LUI.
    assign opB = srcBImm ? imm : rs2Data;  // OP-IMM.

    alu uAlu (
        .opA   (opA),
        .opB   (opB),
        .opSel (opSel),
        .result(result)
    );

    // ------------------------------------------------------------------------
    // Write enable and write-back report
    // ------------------------------------------------------------------------

    assign reject = opIllegal | error;
    assign wrEn   = instrValid & ~reject & (rd != '0);

    always_ff @(posedge clk) begin : wbReport
        if (rst) begin
            wbValid <= definitions::LOW;
            wbAddr  <= '0;
            wbData  <= '0;
            illegal <= definitions::LOW;
        end else begin
            wbValid <= wrEn;
            wbAddr  <= rd;
            wbData  <= result;
            illegal <= instrValid & reject;  // Rejected instructions report regardless of rd.
        end
    end

endmodule : exec_core

// File: rtl/main_decoder.sv
`timescale 1ns/1ps

`include "core_cfg.svh"

module main_decoder (
    input  definitions::word_t    instr,
    output definitions::regAddr_t rs1,
    output definitions::regAddr_t rs2,
    output definitions::regAddr_t rd,
    output logic [2:0]            funct3,
    output logic [6:0]            funct7,
    output definitions::word_t    imm,
    output definitions::aluOp_t   aluOp,
    output definitions::flag_t    srcAImm,
    output definitions::flag_t    srcBImm,
    output definitions::flag_t    opIllegal
);

    definitions::opcode_t opcode;
    definitions::word_t   iImm;
    definitions::word_t   uImm;
    definitions::flag_t   isLui;

    // ------------------------------------------------------------------------
    // Field extraction
    // ------------------------------------------------------------------------

    assign opcode = definitions::opcode_t'(instr[6:0]);

    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    // ------------------------------------------------------------------------
    // Immediates
    // ------------------------------------------------------------------------

    assign iImm = {{(`XLEN-12){instr[31]}}, instr[31:20]};  // Sign-extended I-type.
    assign uImm = {instr[31:12], 12'b0};                    // Upper 20 bits, low 12 clear.

    assign isLui = (opcode == definitions::LUI) ? definitions::HIGH : definitions::LOW;
    assign imm   = isLui ? uImm : iImm;

    // ------------------------------------------------------------------------
    // Opcode decode
    // ------------------------------------------------------------------------

    always_comb begin : opcodeDecode
        aluOp     = definitions::TYPE_I;  // Default for unknown opcodes too.
        srcAImm   = definitions::LOW;
        srcBImm   = definitions::LOW;
        opIllegal = definitions::LOW;
        case (opcode)
            definitions::OP_IMM: begin
                aluOp   = definitions::TYPE_I;
                srcBImm = definitions::HIGH;  // rs1 op imm.
            end
            definitions::OP: begin
                aluOp = definitions::TYPE_R;  // rs1 op rs2.
            end
            definitions::LUI: begin
                aluOp   = definitions::PASS_S1;
                srcAImm = definitions::HIGH;  // Immediate goes straight through.
            end
            default: begin
                opIllegal = definitions::HIGH;
            end
        endcase
    end

endmodule : main_decoder

// File: rtl/reg_file.sv
`timescale 1ns/1ps

`include "core_cfg.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  rst,
    input  definitions::regAddr_t rs1Addr,
    input  definitions::regAddr_t rs2Addr,
    input  definitions::regAddr_t wrAddr,
    input  definitions::flag_t    wrEn,
    input  definitions::word_t    wrData,
    output definitions::word_t    rs1Data,
    output definitions::word_t    rs2Data
);

    definitions::word_t regs [`REG_COUNT];

    always_ff @(posedge clk) begin : regWrite
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != '0)) begin
            regs[wrAddr] <= wrData;  // x0 is never written.
        end
    end

    // A read in the write cycle sees the old value.
    assign rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];

endmodule : reg_file

// File: sim.f
+incdir+include
rtl/definitions.sv
rtl/main_decoder.sv
rtl/alu_op.sv
rtl/alu.sv
rtl/reg_file.sv
rtl/exec_core.sv
tests/exec_core_properties.sv
tests/exec_core_tb.sv

// File: tests/exec_core_properties.sv
`timescale 1ns/1ps

module exec_core_properties (
    input logic                  clk,
    input logic                  rst,
    input definitions::flag_t    instrValid,
    input definitions::flag_t    wbValid,
    input definitions::regAddr_t wbAddr,
    input definitions::flag_t    illegal
);

    int failCount = 0;  // Read by the testbench for the closing report.

    // ------------------------------------------------------------------------
    // Report pulses
    // ------------------------------------------------------------------------

    aExclusive : assert property (@(posedge clk) disable iff (rst)
        !(wbValid && illegal))
    else begin
        failCount++;
        $error("wbValid and illegal are high in the same cycle");
    end

    aFollowsStrobe : assert property (@(posedge clk) disable iff (rst)
        (wbValid || illegal) |-> $past(instrValid))
    else begin
        failCount++;
        $error("Report pulse without an instruction strobe one cycle earlier");
    end

    aNoZeroWrite : assert property (@(posedge clk) disable iff (rst)
        wbValid |-> (wbAddr != '0))
    else begin
        failCount++;
        $error("Write-back reported for register zero");
    end

    // Outputs come out of reset quiet.
    aResetQuiet : assert property (@(posedge clk)
        $past(rst) |-> (!wbValid && !illegal))
    else begin
        failCount++;
        $error("Report pulse in the cycle after reset");
    end

endmodule : exec_core_properties

// File: tests/exec_core_tb.sv
`timescale 1ns/1ps

`include "core_cfg.svh"

module exec_core_tb;

    localparam int DIRECTED_COUNT = 64;  // Upper bound on directed instructions.
    localparam int RANDOM_COUNT   = 400;
    localparam int TIMEOUT_NS     = (DIRECTED_COUNT + RANDOM_COUNT + 20) * 8;

    logic                  clk;
    logic                  rst;
    definitions::flag_t    instrValid;
    definitions::word_t    instr;
    definitions::flag_t    wbValid;
    definitions::regAddr_t wbAddr;
    definitions::word_t    wbData;
    definitions::flag_t    illegal;

    definitions::word_t    model [`REG_COUNT];
    logic                  expWbValid;
    logic                  expIllegal;
    definitions::regAddr_t expAddr;
    definitions::word_t    expData;
    int                    errCount;
    integer                seed;

    exec_core dut (
        .clk       (clk),
        .rst       (rst),
        .instrValid(instrValid),
        .instr     (instr),
        .wbValid   (wbValid),
        .wbAddr    (wbAddr),
        .wbData    (wbData),
        .illegal   (illegal)
    );

    bind exec_core exec_core_properties uProps (
        .clk       (clk),
        .rst       (rst),
        .instrValid(instrValid),
        .wbValid   (wbValid),
        .wbAddr    (wbAddr),
        .illegal   (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Instruction encoders
    // ------------------------------------------------------------------------

    function automatic definitions::word_t encR(input logic [6:0] f7, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3,
                                                input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, definitions::OP};
    endfunction

    function automatic definitions::word_t encI(input int imm, input logic [4:0] rs1,
                                                input logic [2:0] f3, input logic [4:0] rd);
        return {12'(imm), rs1, f3, rd, definitions::OP_IMM};
    endfunction

    function automatic definitions::word_t encU(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, definitions::LUI};
    endfunction

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------

    // RV32I arithmetic by funct3 where alt selects SUB and SRA.
    function automatic definitions::word_t refOp(input logic [2:0] f3, input logic alt,
                                                 input definitions::word_t a,
                                                 input definitions::word_t b);
        case (f3)
            3'd0: return alt ? (a - b) : (a + b);
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt)
                    return $unsigned($signed(a) >>> b[4:0]);
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic predict(input definitions::word_t ins, input logic valid);
        logic [6:0]         opc;
        logic [2:0]         f3;
        logic [6:0]         f7;
        logic [4:0]         rd;
        definitions::word_t a;
        definitions::word_t b;
        definitions::word_t immI;
        definitions::word_t res;
        logic               bad;
        opc  = ins[6:0];
        rd   = ins[11:7];
        f3   = ins[14:12];
        f7   = ins[31:25];
        a    = model[ins[19:15]];
        b    = model[ins[24:20]];
        immI = {{20{ins[31]}}, ins[31:20]};
        bad  = 1'b0;
        res  = '0;
        case (opc)
            definitions::OP_IMM: begin
                if (f3 inside {3'd1, 3'd3, 3'd5})
                    bad = 1'b1;  // Shift-imm and SLTIU are rejected.
                else
                    res = refOp(f3, 1'b0, a, immI);
            end
            definitions::OP: begin
                if (f7 == 7'd0)
                    res = refOp(f3, 1'b0, a, b);
                else if (f7 == 7'd32 && (f3 == 3'd0 || f3 == 3'd5))
                    res = refOp(f3, 1'b1, a, b);
                else
                    bad = 1'b1;
            end
            definitions::LUI: res = {ins[31:12], 12'h000};
            default: bad = 1'b1;
        endcase
        expWbValid = valid && !bad && (rd != 5'd0);
        expIllegal = valid && bad;
        expAddr    = rd;
        expData    = res;
        if (expWbValid)
            model[rd] = res;
    endtask

    task automatic checkReport();
        assert (wbValid === expWbValid) else begin
            errCount++;
            $display("Mismatch wbValid: got %h, expected %h", wbValid, expWbValid);
        end
        assert (illegal === expIllegal) else begin
            errCount++;
            $display("Mismatch illegal: got %h, expected %h", illegal, expIllegal);
        end
        if (expWbValid) begin
            assert (wbAddr === expAddr) else begin
                errCount++;
                $display("Mismatch wbAddr: got %h, expected %h", wbAddr, expAddr);
            end
            assert (wbData === expData) else begin
                errCount++;
                $display("Mismatch wbData: got %h, expected %h", wbData, expData);
            end
        end
    endtask

    // One instruction per cycle with the previous report checked at the negedge.
    task automatic issue(input definitions::word_t ins, input logic valid);
        @(posedge clk);
        instrValid <= valid;
        instr      <= ins;
        @(negedge clk);
        checkReport();
        predict(ins, valid);
    endtask

    task automatic runRandom();
        definitions::word_t ins;
        logic               valid;
        int                 pick;
        for (int n = 0; n < RANDOM_COUNT; n++) begin
            ins  = $random(seed);
            pick = $unsigned($random(seed)) % 4;
            case (pick)
                0: ins[6:0] = definitions::OP;
                1: ins[6:0] = definitions::OP_IMM;
                2: ins[6:0] = definitions::LUI;
                default: ins[6:0] = 7'b0000011;  // Load, unknown here.
            endcase
            pick = $unsigned($random(seed)) % 4;
            if (pick == 0)
                ins[31:25] = 7'd0;
            else if (pick == 1)
                ins[31:25] = 7'd32;
            valid = ($unsigned($random(seed)) % 8) != 0;
            issue(ins, valid);
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------

    initial begin
        rst        = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        expWbValid = 1'b0;
        expIllegal = 1'b0;
        expAddr    = '0;
        expData    = '0;
        errCount   = 0;
        seed       = 32'ha15717ed;
        for (int i = 0; i < `REG_COUNT; i++)
            model[i] = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        issue(encR(7'd0, 5'd16, 5'd15, 3'd0, 5'd9), 1'b1);  // Reset state reads zero.
        issue(encI(100, 5'd0, 3'd0, 5'd1), 1'b1);
        issue(encI(-7, 5'd0, 3'd0, 5'd2), 1'b1);
        issue(encI(-2048, 5'd0, 3'd0, 5'd3), 1'b1);
        issue(encI(5, 5'd0, 3'd0, 5'd4), 1'b1);
        issue(encI(2047, 5'd0, 3'd0, 5'd5), 1'b1);
        for (int f = 0; f < 8; f++)
            issue(encR(7'd0, 5'd4, 5'd2, 3'(f), 5'(10 + f)), 1'b1);
        issue(encR(7'd32, 5'd2, 5'd1, 3'd0, 5'd18), 1'b1);  // SUB.
        issue(encR(7'd32, 5'd4, 5'd3, 3'd5, 5'd19), 1'b1);  // SRA of a negative.
        issue(encR(7'd0, 5'd2, 5'd4, 3'd2, 5'd21), 1'b1);
        issue(encR(7'd0, 5'd2, 5'd4, 3'd3, 5'd22), 1'b1);

        issue(encI(-300, 5'd1, 3'd0, 5'd23), 1'b1);
        issue(encI(-5, 5'd2, 3'd2, 5'd24), 1'b1);
        issue(encI(-1, 5'd5, 3'd4, 5'd25), 1'b1);
        issue(encI(-256, 5'd1, 3'd6, 5'd26), 1'b1);
        issue(encI(-16, 5'd2, 3'd7, 5'd27), 1'b1);
        issue(encI(3, 5'd1, 3'd1, 5'd10), 1'b1);   // SLLI.
        issue(encI(3, 5'd1, 3'd5, 5'd10), 1'b1);   // SRLI.
        issue(encI(9, 5'd1, 3'd3, 5'd10), 1'b1);   // SLTIU.
        issue(encR(7'd0, 5'd0, 5'd10, 3'd0, 5'd28), 1'b1);

        issue(encU(20'habcde, 5'd6), 1'b1);
        issue(encU(20'h80000, 5'd7), 1'b1);

        issue({20'habcde, 5'd1, 7'b1100011}, 1'b1);  // Branch opcode into x1.
        issue(encR(7'd1, 5'd2, 5'd1, 3'd0, 5'd1), 1'b1);
        issue(encR(7'd32, 5'd2, 5'd1, 3'd4, 5'd1), 1'b1);
        issue(encR(7'd32, 5'd2, 5'd1, 3'd1, 5'd1), 1'b1);
        issue(encR(7'd0, 5'd0, 5'd1, 3'd0, 5'd29), 1'b1);

        issue(encI(55, 5'd1, 3'd0, 5'd0), 1'b1);
        issue(encR(7'd0, 5'd2, 5'd1, 3'd0, 5'd0), 1'b1);
        issue({25'h0, 7'b1111111}, 1'b1);
        issue(encR(7'd0, 5'd1, 5'd0, 3'd0, 5'd30), 1'b1);

        repeat (4) issue(encI(1, 5'd8, 3'd0, 5'd8), 1'b1);
        issue(encR(7'd0, 5'd8, 5'd8, 3'd0, 5'd31), 1'b1);
        issue(encR(7'd32, 5'd2, 5'd31, 3'd0, 5'd31), 1'b1);
        issue('0, 1'b0);

        runRandom();
        issue('0, 1'b0);
        issue('0, 1'b0);

        $display("Errors: %0d mismatches, %0d assertion failures",
                 errCount, dut.uProps.failCount);
        if (errCount == 0 && dut.uProps.failCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule : exec_core_tb
